/* hdl/ldqConflictMatch.sv */
// purely combinational; the caller qualifies the result with its own enables and busy state
`timescale 1ns/1ps

module ldqConflictMatch (
  input  ldqPkg::halfSelT  entryHalf,
  input  ldqPkg::halfSelT  checkHalf,
  input  ldqPkg::lineAddrT entryAddrEven,
  input  ldqPkg::lineAddrT entryAddrOdd,
  input  ldqPkg::lineAddrT checkAddrEven,
  input  ldqPkg::lineAddrT checkAddrOdd,
  input  ldqPkg::bankMaskT entryBanks,
  input  ldqPkg::bankMaskT checkBanks,
  input  ldqPkg::bankLowT  entryBankLow,
  input  ldqPkg::bankLowT  checkBankLow,
  output logic             conflict
);

  localparam int HW = ldqPkg::BANK_HALF_WIDTH;

  logic evenMatch;
  logic oddMatch;
  logic lowOverlap;
  logic highOverlap;
  logic byteOverlap;
  ldqPkg::halfSelT halfHit;

  assign evenMatch = entryAddrEven == checkAddrEven;
  assign oddMatch = entryAddrOdd == checkAddrOdd;
  assign lowOverlap = |(entryBanks[HW-1:0] & checkBanks[HW-1:0]);
  assign highOverlap = |(entryBanks[2*HW-1:HW] & checkBanks[2*HW-1:HW]);
  assign byteOverlap = |(entryBankLow & checkBankLow);

  // a half counts only if both sides use it
  assign halfHit[ldqPkg::HALF_OH] = entryHalf[ldqPkg::HALF_OH] & checkHalf[ldqPkg::HALF_OH] &
                                    oddMatch & highOverlap;
  assign halfHit[ldqPkg::HALF_EH] = entryHalf[ldqPkg::HALF_EH] & checkHalf[ldqPkg::HALF_EH] &
                                    evenMatch & highOverlap;
  assign halfHit[ldqPkg::HALF_OL] = entryHalf[ldqPkg::HALF_OL] & checkHalf[ldqPkg::HALF_OL] &
                                    oddMatch & lowOverlap;
  assign halfHit[ldqPkg::HALF_EL] = entryHalf[ldqPkg::HALF_EL] & checkHalf[ldqPkg::HALF_EL] &
                                    evenMatch & lowOverlap;

  assign conflict = (|halfHit) & byteOverlap;

endmodule

/* hdl/ldqEntry.sv */
// one queue slot; write must only hit a free slot, the array guarantees this
`timescale 1ns/1ps

module ldqEntry (
  input  logic           clk,
  input  logic           rst,
  ldqNewIf.sink          load,
  ldqCheckIf.sink        check,
  input  logic           write,
  input  logic           writeConfl,
  input  logic           flushEn,
  input  logic           flushThread,
  input  logic           retireEn,
  input  ldqPkg::seqTagT retireTag,
  output logic           busy,
  output logic           retireHit,
  output logic           conflState,
  output logic           thread
);

  ldqPkg::lineAddrT addrEven;
  ldqPkg::lineAddrT addrOdd;
  ldqPkg::bankMaskT banks;
  ldqPkg::bankLowT bankLow;
  ldqPkg::halfSelT halfSel;
  ldqPkg::seqTagT tag;
  logic confl;
  logic rawMatch;
  logic checkHit;
  logic store;

  ldqConflictMatch matchInst (
    .entryHalf(halfSel),
    .checkHalf(check.halfSel),
    .entryAddrEven(addrEven),
    .entryAddrOdd(addrOdd),
    .checkAddrEven(check.addrEven),
    .checkAddrOdd(check.addrOdd),
    .entryBanks(banks),
    .checkBanks(check.banks),
    .entryBankLow(bankLow),
    .checkBankLow(check.bankLow),
    .conflict(rawMatch)
  );

  assign store = write & load.en;
  assign checkHit = busy & check.en & rawMatch;
  assign retireHit = busy && (tag == retireTag);
  assign conflState = confl | checkHit;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      confl <= 1'b0;
    end else if (store) begin
      busy <= 1'b1;
      confl <= writeConfl;
    end else if (flushEn && flushThread == thread) begin
      // flush beats a retire of the same slot
      busy <= 1'b0;
    end else if (retireEn && retireHit) begin
      busy <= 1'b0;
    end else if (checkHit) begin
      confl <= 1'b1;
    end
  end

  // load payload
  always_ff @(posedge clk) begin
    if (store) begin
      addrEven <= load.addrEven;
      addrOdd <= load.addrOdd;
      banks <= load.banks;
      bankLow <= load.bankLow;
      halfSel <= load.halfSel;
      tag <= load.tag;
      thread <= load.thread;
    end
  end

endmodule

/* hdl/ldqEntryArray.sv */
// needs two free slots whenever both accepts are high; the occupancy stall level ensures it
`timescale 1ns/1ps

module ldqEntryArray #(
  parameter int ENTRY_COUNT = 8
) (
  input  logic           clk,
  input  logic           rst,
  ldqNewIf.sink          newPort0,
  ldqNewIf.sink          newPort1,
  ldqCheckIf.sink        check,
  input  logic           accept0,
  input  logic           accept1,
  input  logic           flushEn,
  input  logic           flushThread,
  input  logic           retireEn,
  input  ldqPkg::seqTagT retireTag,
  ldqRetireIf.source     result
);

  logic [ENTRY_COUNT-1:0] busyVec;
  logic [ENTRY_COUNT-1:0] lowSel;
  logic [ENTRY_COUNT-1:0] highSel;
  logic [ENTRY_COUNT-1:0] wr0;
  logic [ENTRY_COUNT-1:0] wr1;
  logic [ENTRY_COUNT-1:0] entHit;
  logic [ENTRY_COUNT-1:0] entConfl;
  logic [ENTRY_COUNT-1:0] entThread;
  logic [ENTRY_COUNT-1:0] hitVec;
  logic newMatch0;
  logic newMatch1;
  logic newConfl0;
  logic newConfl1;

  // lowest free slot for port 0
  always_comb begin
    lowSel = '0;
    for (int i = ENTRY_COUNT - 1; i >= 0; i--) begin
      if (!busyVec[i]) begin
        lowSel = '0;
        lowSel[i] = 1'b1;
      end
    end
  end

  // highest free slot for port 1
  always_comb begin
    highSel = '0;
    for (int i = 0; i < ENTRY_COUNT; i++) begin
      if (!busyVec[i]) begin
        highSel = '0;
        highSel[i] = 1'b1;
      end
    end
  end

  assign wr0 = lowSel & {ENTRY_COUNT{accept0}};
  assign wr1 = highSel & {ENTRY_COUNT{accept1}};

  // store arriving together with the new loads
  ldqConflictMatch newMatchInst0 (
    .entryHalf(newPort0.halfSel),
    .checkHalf(check.halfSel),
    .entryAddrEven(newPort0.addrEven),
    .entryAddrOdd(newPort0.addrOdd),
    .checkAddrEven(check.addrEven),
    .checkAddrOdd(check.addrOdd),
    .entryBanks(newPort0.banks),
    .checkBanks(check.banks),
    .entryBankLow(newPort0.bankLow),
    .checkBankLow(check.bankLow),
    .conflict(newMatch0)
  );

  ldqConflictMatch newMatchInst1 (
    .entryHalf(newPort1.halfSel),
    .checkHalf(check.halfSel),
    .entryAddrEven(newPort1.addrEven),
    .entryAddrOdd(newPort1.addrOdd),
    .checkAddrEven(check.addrEven),
    .checkAddrOdd(check.addrOdd),
    .entryBanks(newPort1.banks),
    .checkBanks(check.banks),
    .entryBankLow(newPort1.bankLow),
    .checkBankLow(check.bankLow),
    .conflict(newMatch1)
  );

  assign newConfl0 = check.en & newMatch0;
  assign newConfl1 = check.en & newMatch1;

  for (genvar i = 0; i < ENTRY_COUNT; i++) begin : entryGen
    ldqNewIf entryLoad ();

    // port 1 owns the slot only when it writes there
    assign entryLoad.en = wr1[i] ? newPort1.en : newPort0.en;
    assign entryLoad.addrEven = wr1[i] ? newPort1.addrEven : newPort0.addrEven;
    assign entryLoad.addrOdd = wr1[i] ? newPort1.addrOdd : newPort0.addrOdd;
    assign entryLoad.banks = wr1[i] ? newPort1.banks : newPort0.banks;
    assign entryLoad.bankLow = wr1[i] ? newPort1.bankLow : newPort0.bankLow;
    assign entryLoad.halfSel = wr1[i] ? newPort1.halfSel : newPort0.halfSel;
    assign entryLoad.tag = wr1[i] ? newPort1.tag : newPort0.tag;
    assign entryLoad.thread = wr1[i] ? newPort1.thread : newPort0.thread;

    ldqEntry entryInst (
      .clk(clk),
      .rst(rst),
      .load(entryLoad),
      .check(check),
      .write(wr0[i] | wr1[i]),
      .writeConfl(wr1[i] ? newConfl1 : newConfl0),
      .flushEn(flushEn),
      .flushThread(flushThread),
      .retireEn(retireEn),
      .retireTag(retireTag),
      .busy(busyVec[i]),
      .retireHit(entHit[i]),
      .conflState(entConfl[i]),
      .thread(entThread[i])
    );

    // flushed slot reports a miss
    assign hitVec[i] = retireEn & entHit[i] & ~(flushEn & (entThread[i] == flushThread));
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result.valid <= 1'b0;
      result.hit <= 1'b0;
      result.confl <= 1'b0;
      result.thread <= 1'b0;
    end else begin
      result.valid <= retireEn;
      result.hit <= |hitVec;
      result.confl <= |(hitVec & entConfl);
      result.thread <= |(hitVec & entThread);
    end
  end

endmodule

/* hdl/ldqIfs.sv */
// load-queue interfaces; all signals are driven by the top or the entry array, no handshake back
`timescale 1ns/1ps

// one new-load port
interface ldqNewIf;
  logic en;
  ldqPkg::lineAddrT addrEven;
  ldqPkg::lineAddrT addrOdd;
  ldqPkg::bankMaskT banks;
  ldqPkg::bankLowT bankLow;
  ldqPkg::halfSelT halfSel;
  ldqPkg::seqTagT tag;
  logic thread;

  modport sink (
    input en, addrEven, addrOdd, banks, bankLow, halfSel, tag, thread
  );

  // occupancy only needs to know who asks
  modport monitor (
    input en, thread
  );
endinterface

// store-check port
interface ldqCheckIf;
  logic en;
  ldqPkg::lineAddrT addrEven;
  ldqPkg::lineAddrT addrOdd;
  ldqPkg::bankMaskT banks;
  ldqPkg::bankLowT bankLow;
  ldqPkg::halfSelT halfSel;

  modport sink (
    input en, addrEven, addrOdd, banks, bankLow, halfSel
  );
endinterface

// registered retire result
interface ldqRetireIf;
  logic valid;
  logic hit;
  logic confl;
  logic thread;

  modport source (
    output valid, hit, confl, thread
  );

  modport monitor (
    input valid, hit, thread
  );
endinterface

/* hdl/ldqOccupancy.sv */
// counts lag a retire by one cycle, so they never undercount the occupied slots
`timescale 1ns/1ps

module ldqOccupancy #(
  parameter int ENTRY_COUNT = 8
) (
  input  logic        clk,
  input  logic        rst,
  ldqNewIf.monitor    newPort0,
  ldqNewIf.monitor    newPort1,
  input  logic        flushEn,
  input  logic        flushThread,
  ldqRetireIf.monitor result,
  output logic        accept0,
  output logic        accept1,
  output logic        doStall
);

  localparam int CNT_WIDTH = $clog2(ENTRY_COUNT + 1);
  localparam int STALL_LEVEL = ENTRY_COUNT - 1;

  typedef logic [CNT_WIDTH-1:0] countT;

  countT count [2];
  countT countNext [2];
  logic [CNT_WIDTH:0] total;

  assign total = count[0] + count[1];
  assign doStall = total >= STALL_LEVEL[CNT_WIDTH:0];

  // a flushing thread cannot allocate
  assign accept0 = newPort0.en & ~doStall & ~(flushEn & (newPort0.thread == flushThread));
  assign accept1 = newPort1.en & ~doStall & ~(flushEn & (newPort1.thread == flushThread));

  always_comb begin
    for (int t = 0; t < 2; t++) begin
      countNext[t] = count[t];
      if (accept0 && newPort0.thread == t[0]) begin
        countNext[t] = countNext[t] + 1'b1;
      end
      if (accept1 && newPort1.thread == t[0]) begin
        countNext[t] = countNext[t] + 1'b1;
      end
      if (result.valid && result.hit && result.thread == t[0]) begin
        countNext[t] = countNext[t] - 1'b1;
      end
      // flush overrides everything else this cycle
      if (flushEn && flushThread == t[0]) begin
        countNext[t] = '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count[0] <= '0;
      count[1] <= '0;
    end else begin
      count[0] <= countNext[0];
      count[1] <= countNext[1];
    end
  end

endmodule

/* hdl/ldqPkg.sv */
// load-queue field widths; line address 12 bits, tags 6 bits, one thread bit with no typedef
package ldqPkg;

  // line address of an even or odd line
  localparam int LINE_ADDR_WIDTH = 12;
  typedef logic [LINE_ADDR_WIDTH-1:0] lineAddrT;

  // 32 banks, low half in [15:0], high half in [31:16]
  localparam int BANK_COUNT = 32;
  localparam int BANK_HALF_WIDTH = BANK_COUNT / 2;
  typedef logic [BANK_COUNT-1:0] bankMaskT;

  // byte mask inside the low bank
  typedef logic [3:0] bankLowT;

  // one flag per half
  typedef logic [3:0] halfSelT;
  localparam int HALF_OH = 3;
  localparam int HALF_EH = 2;
  localparam int HALF_OL = 1;
  localparam int HALF_EL = 0;

  // sequence tag used to retire a load
  localparam int SEQ_TAG_WIDTH = 6;
  typedef logic [SEQ_TAG_WIDTH-1:0] seqTagT;

endpackage

/* hdl/loadQueue.sv */
// two-thread load queue; ENTRY_COUNT must be 4 or more, retire result arrives one cycle late
`timescale 1ns/1ps

module loadQueue #(
  parameter int ENTRY_COUNT = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             new0En,
  input  ldqPkg::lineAddrT new0AddrEven,
  input  ldqPkg::lineAddrT new0AddrOdd,
  input  ldqPkg::bankMaskT new0Banks,
  input  ldqPkg::bankLowT  new0BankLow,
  input  ldqPkg::halfSelT  new0HalfSel,
  input  ldqPkg::seqTagT   new0Tag,
  input  logic             new0Thread,
  input  logic             new1En,
  input  ldqPkg::lineAddrT new1AddrEven,
  input  ldqPkg::lineAddrT new1AddrOdd,
  input  ldqPkg::bankMaskT new1Banks,
  input  ldqPkg::bankLowT  new1BankLow,
  input  ldqPkg::halfSelT  new1HalfSel,
  input  ldqPkg::seqTagT   new1Tag,
  input  logic             new1Thread,
  input  logic             chkEn,
  input  ldqPkg::lineAddrT chkAddrEven,
  input  ldqPkg::lineAddrT chkAddrOdd,
  input  ldqPkg::bankMaskT chkBanks,
  input  ldqPkg::bankLowT  chkBankLow,
  input  ldqPkg::halfSelT  chkHalfSel,
  input  logic             flushEn,
  input  logic             flushThread,
  input  logic             retireEn,
  input  ldqPkg::seqTagT   retireTag,
  output logic             retireValid,
  output logic             retireHit,
  output logic             retireConfl,
  output logic             retireThread,
  output logic             doStall
);

  ldqNewIf newPort0 ();
  ldqNewIf newPort1 ();
  ldqCheckIf check ();
  ldqRetireIf result ();

  logic accept0;
  logic accept1;

  assign newPort0.en = new0En;
  assign newPort0.addrEven = new0AddrEven;
  assign newPort0.addrOdd = new0AddrOdd;
  assign newPort0.banks = new0Banks;
  assign newPort0.bankLow = new0BankLow;
  assign newPort0.halfSel = new0HalfSel;
  assign newPort0.tag = new0Tag;
  assign newPort0.thread = new0Thread;

  assign newPort1.en = new1En;
  assign newPort1.addrEven = new1AddrEven;
  assign newPort1.addrOdd = new1AddrOdd;
  assign newPort1.banks = new1Banks;
  assign newPort1.bankLow = new1BankLow;
  assign newPort1.halfSel = new1HalfSel;
  assign newPort1.tag = new1Tag;
  assign newPort1.thread = new1Thread;

  assign check.en = chkEn;
  assign check.addrEven = chkAddrEven;
  assign check.addrOdd = chkAddrOdd;
  assign check.banks = chkBanks;
  assign check.bankLow = chkBankLow;
  assign check.halfSel = chkHalfSel;

  assign retireValid = result.valid;
  assign retireHit = result.hit;
  assign retireConfl = result.confl;
  assign retireThread = result.thread;

  ldqEntryArray #(
    .ENTRY_COUNT(ENTRY_COUNT)
  ) arrayInst (
    .clk(clk),
    .rst(rst),
    .newPort0(newPort0),
    .newPort1(newPort1),
    .check(check),
    .accept0(accept0),
    .accept1(accept1),
    .flushEn(flushEn),
    .flushThread(flushThread),
    .retireEn(retireEn),
    .retireTag(retireTag),
    .result(result)
  );

  // decides acceptance for both ports
  ldqOccupancy #(
    .ENTRY_COUNT(ENTRY_COUNT)
  ) occupancyInst (
    .clk(clk),
    .rst(rst),
    .newPort0(newPort0),
    .newPort1(newPort1),
    .flushEn(flushEn),
    .flushThread(flushThread),
    .result(result),
    .accept0(accept0),
    .accept1(accept1),
    .doStall(doStall)
  );

endmodule

/* run.sh */
#!/usr/bin/env bash
# builds and runs the loadQueue testbench with Verilator, result taken from sim.log

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tbLoadQueue \
  -f tb.f -o simLoadQueue
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/simLoadQueue > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Simulation failed" "$log"; then
  echo "result: FAIL"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
if ! grep -q "Simulation passed" "$log"; then
  echo "no pass line found in $log"
  exit 1
fi
echo "result: PASS"

/* sim/loadQueue_assert.sv */
// bound to loadQueue; covers retire timing, retire flags and doStall around reset only
`timescale 1ns/1ps

module loadQueueAssert (
  input logic clk,
  input logic rst,
  input logic retireEn,
  input logic retireValid,
  input logic retireHit,
  input logic retireConfl,
  input logic doStall
);

  // result exactly one cycle after the request
  validAfterRequest: assert property (@(posedge clk) disable iff (rst)
    retireEn |=> retireValid)
    else $error("retireValid missing one cycle after retireEn");

  validOnlyAfterRequest: assert property (@(posedge clk) disable iff (rst)
    retireValid |-> $past(retireEn))
    else $error("retireValid without retireEn one cycle before");

  conflNeedsHit: assert property (@(posedge clk) disable iff (rst)
    retireConfl |-> retireHit)
    else $error("retireConfl raised without retireHit");

  // counts are cleared by reset
  stallLowAfterReset: assert property (@(posedge clk)
    $past(rst) |-> !doStall)
    else $error("doStall high during or right after reset");

endmodule

bind loadQueue loadQueueAssert assertInst (.*);

/* sim/tbLoadQueue.sv */
// directed testbench for loadQueue with ENTRY_COUNT 8; stops at the first mismatch or timeout
`timescale 1ns/1ps

module tbLoadQueue;

  // address and mask fields shared by a load and a store check
  typedef struct packed {
    ldqPkg::lineAddrT ev;
    ldqPkg::lineAddrT od;
    ldqPkg::bankMaskT banks;
    ldqPkg::bankLowT bl;
    ldqPkg::halfSelT hs;
  } accT;

  logic clk, rst;
  logic new0En, new1En, new0Thread, new1Thread, chkEn, flushEn, flushThread, retireEn;
  ldqPkg::lineAddrT new0AddrEven, new0AddrOdd, new1AddrEven, new1AddrOdd, chkAddrEven, chkAddrOdd;
  ldqPkg::bankMaskT new0Banks, new1Banks, chkBanks;
  ldqPkg::bankLowT new0BankLow, new1BankLow, chkBankLow;
  ldqPkg::halfSelT new0HalfSel, new1HalfSel, chkHalfSel;
  ldqPkg::seqTagT new0Tag, new1Tag, retireTag;
  logic retireValid, retireHit, retireConfl, retireThread, doStall;
  logic [31:0] rng;

  loadQueue #(.ENTRY_COUNT(8)) UUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic accT randAcc();
    accT a;
    rng = xorshift(rng);
    a.ev = rng[11:0];
    a.od = rng[27:16];
    rng = xorshift(rng);
    a.banks = rng;
    rng = xorshift(rng);
    a.bl = rng[3:0];
    a.hs = rng[7:4];
    return a;
  endfunction

  // half bits 3 to 0 are odd-high, even-high, odd-low, even-low
  function automatic logic conflictModel(input accT ld, input accT st);
    logic anyHalf;
    logic sameLine;
    logic bankHit;
    anyHalf = 1'b0;
    for (int h = 0; h < 4; h++) begin
      sameLine = h[0] ? (ld.od == st.od) : (ld.ev == st.ev);
      bankHit = h[1] ? |(ld.banks[31:16] & st.banks[31:16]) : |(ld.banks[15:0] & st.banks[15:0]);
      if (ld.hs[h] && st.hs[h] && sameLine && bankHit) anyHalf = 1'b1;
    end
    return anyHalf && |(ld.bl & st.bl);
  endfunction

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      abortRun($sformatf("ERROR at %0t ns: %s got %0h expected %0h", $time, what, got, exp));
    end
  endtask

  task automatic offerLoad(input int p, input accT a, input ldqPkg::seqTagT tag, input logic thr);
    if (p == 0) begin
      new0En = 1'b1;
      {new0AddrEven, new0AddrOdd, new0Banks, new0BankLow, new0HalfSel} = a;
      new0Tag = tag;
      new0Thread = thr;
    end else begin
      new1En = 1'b1;
      {new1AddrEven, new1AddrOdd, new1Banks, new1BankLow, new1HalfSel} = a;
      new1Tag = tag;
      new1Thread = thr;
    end
  endtask

  task automatic storeCheck(input accT a);
    chkEn = 1'b1;
    {chkAddrEven, chkAddrOdd, chkBanks, chkBankLow, chkHalfSel} = a;
  endtask

  // one clock, then all strobes low again
  task automatic cycle();
    @(negedge clk);
    new0En = 1'b0;
    new1En = 1'b0;
    chkEn = 1'b0;
    flushEn = 1'b0;
    retireEn = 1'b0;
  endtask

  task automatic retireExpect(input ldqPkg::seqTagT tag, input logic hit, input logic confl,
                              input logic thr);
    int waited;
    retireEn = 1'b1;
    retireTag = tag;
    waited = 0;
    do begin
      @(negedge clk);
      retireEn = 1'b0;
      waited++;
    end while (!retireValid && waited < 5);
    if (!retireValid) abortRun($sformatf("timeout: no retire result for tag %0d", tag));
    compare(waited, 1, "retire latency");
    compare(retireHit, hit, $sformatf("retireHit for tag %0d", tag));
    compare(retireConfl, confl, $sformatf("retireConfl for tag %0d", tag));
    if (hit) compare(retireThread, thr, $sformatf("retireThread for tag %0d", tag));
  endtask

  task automatic waitStallLow();
    int n;
    n = 0;
    while (doStall && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (doStall) abortRun("timeout: doStall stayed high after a retire hit");
  endtask

  task automatic afterResetMiss();
    compare(doStall, 0, "doStall after reset");
    rng = xorshift(rng);
    retireExpect(ldqPkg::seqTagT'(rng), 1'b0, 1'b0, 1'b0);
  endtask

  task automatic dualAllocation();
    offerLoad(0, randAcc(), 6'd1, 1'b0);
    offerLoad(1, randAcc(), 6'd2, 1'b1);
    cycle();
    retireExpect(6'd1, 1'b1, 1'b0, 1'b0);
    retireExpect(6'd2, 1'b1, 1'b0, 1'b1);
    retireExpect(6'd1, 1'b0, 1'b0, 1'b0);
  endtask

  // each half flag against a match, an even line miss, a low bank miss, no byte overlap
  // and a random store on the same lines
  task automatic conflictRuleSweep();
    accT ld;
    accT st;
    logic thr;
    for (int i = 0; i < 20; i++) begin
      ld = randAcc();
      ld.hs = 4'b0001 << (i / 5);
      ld.bl[0] = 1'b1;
      st = ld;
      case (i % 5)
        1: st.ev = ld.ev ^ 12'd1;
        2: st.banks[15:0] = ~ld.banks[15:0];
        3: st.bl = ~ld.bl;
        4: begin
          st = randAcc();
          st.ev = ld.ev;
          st.od = ld.od;
        end
        default: st = ld;
      endcase
      thr = rng[0];
      offerLoad(0, ld, ldqPkg::seqTagT'(10 + i), thr);
      cycle();
      storeCheck(st);
      cycle();
      retireExpect(ldqPkg::seqTagT'(10 + i), 1'b1, conflictModel(ld, st), thr);
    end
  endtask

  task automatic sameCycleConflict();
    accT ld;
    accT other;
    ld = randAcc();
    ld.hs = 4'hf;
    ld.bl[0] = 1'b1;
    ld.banks[0] = 1'b1;
    other = ld;
    other.bl = ~ld.bl;
    offerLoad(0, other, 6'd41, 1'b0);
    offerLoad(1, ld, 6'd40, 1'b1);
    storeCheck(ld);
    cycle();
    retireExpect(6'd40, 1'b1, 1'b1, 1'b1);
    retireExpect(6'd41, 1'b1, conflictModel(other, ld), 1'b0);
  endtask

  task automatic stallAndRelease();
    for (int i = 0; i < 7; i++) begin
      compare(doStall, 0, "doStall while filling");
      offerLoad(0, randAcc(), ldqPkg::seqTagT'(20 + i), i[0]);
      cycle();
    end
    compare(doStall, 1, "doStall with seven loads");
    offerLoad(1, randAcc(), 6'd27, 1'b0);
    cycle();
    retireExpect(6'd27, 1'b0, 1'b0, 1'b0);
    retireExpect(6'd20, 1'b1, 1'b0, 1'b0);
    waitStallLow();
  endtask

  // thread 1 holds tags 21, 23, 25 and thread 0 holds 22, 24, 26
  task automatic flushAndRefill();
    // retire in the flush cycle still misses
    flushEn = 1'b1;
    flushThread = 1'b1;
    retireExpect(6'd21, 1'b0, 1'b0, 1'b0);
    flushEn = 1'b0;
    retireExpect(6'd23, 1'b0, 1'b0, 1'b0);
    retireExpect(6'd22, 1'b1, 1'b0, 1'b0);
    for (int i = 0; i < 5; i++) begin
      compare(doStall, 0, "doStall refilling after flush");
      offerLoad(i % 2, randAcc(), ldqPkg::seqTagT'(30 + i), 1'b1);
      cycle();
    end
    compare(doStall, 1, "doStall after refill");
    retireExpect(6'd34, 1'b1, 1'b0, 1'b1);
  endtask

  initial begin
    rng = 32'd58747;
    rst = 1'b1;
    new0En = 1'b0;
    new1En = 1'b0;
    chkEn = 1'b0;
    flushEn = 1'b0;
    flushThread = 1'b0;
    retireEn = 1'b0;
    retireTag = '0;
    {new0AddrEven, new0AddrOdd, new0Banks, new0BankLow, new0HalfSel, new0Tag, new0Thread} = '0;
    {new1AddrEven, new1AddrOdd, new1Banks, new1BankLow, new1HalfSel, new1Tag, new1Thread} = '0;
    {chkAddrEven, chkAddrOdd, chkBanks, chkBankLow, chkHalfSel} = '0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    afterResetMiss();
    dualAllocation();
    conflictRuleSweep();
    sameCycleConflict();
    stallAndRelease();
    flushAndRefill();
    $display("Simulation passed");
    $finish;
  end

endmodule

/* tb.f */
hdl/ldqPkg.sv
hdl/ldqIfs.sv
hdl/ldqConflictMatch.sv
hdl/ldqEntry.sv
hdl/ldqEntryArray.sv
hdl/ldqOccupancy.sv
hdl/loadQueue.sv
sim/loadQueue_assert.sv
sim/tbLoadQueue.sv
